/* design/noc_defines.svh */
// ****************************************
// NoC path master sizing macros for the
// 2x2 mesh, shared by package and RTL
// ****************************************
`ifndef NOC_DEFINES_SVH
`define NOC_DEFINES_SVH

// mesh of 2x2 routers, one processor each
`define NOC_NUM_NODES 4

// north, south, east, west, processor
`define NOC_NUM_PORTS 5

// width of one router input select
`define NOC_SEL_W 3

// fixed routes in the whole table
`define NOC_NUM_PATHS 28

// route indices owned by one source, source n has 7n to 7n+6
`define NOC_PATHS_PER_SRC 7

// width of a node number
`define NOC_NODE_W 2

`endif

/* design/noc_pkg.sv */
// ****************************************
// NoC path master types: ports, selects,
// requests, router control and routes
// ****************************************
`include "noc_defines.svh"

package noc_pkg;

    // output port of a router, also the hop direction
    typedef enum logic [2:0] {
        NORTH,
        SOUTH,
        EAST,
        WEST,
        PROC
    } port_e;

    // port a flow enters on, for the output it drives
    typedef enum logic [`NOC_SEL_W-1:0] {
        FROM_NORTH = 3'b000,
        FROM_SOUTH = 3'b001,
        FROM_EAST  = 3'b010,
        FROM_WEST  = 3'b011,
        FROM_PROC  = 3'b100
    } in_sel_e;

    typedef struct packed {
        logic [`NOC_NODE_W-1:0] dest;  // target processor
        logic                   req;   // level request
    } proc_req_t;

    typedef struct packed {
        in_sel_e                   sel_north;
        in_sel_e                   sel_south;
        in_sel_e                   sel_east;
        in_sel_e                   sel_west;
        in_sel_e                   sel_proc;
        logic [`NOC_NUM_PORTS-1:0] active;  // n, s, e, w, p from msb
    } router_ctrl_t;

    // one control word per router, index = router number
    typedef router_ctrl_t [`NOC_NUM_NODES-1:0] mesh_ctrl_t;

    typedef struct packed {
        logic       valid;  // requested and path free
        mesh_ctrl_t ctrl;   // only this route's ports active
    } route_t;

endpackage

/* design/route_lookup.sv */
// ****************************************
// route lookup: primary and alternate
// candidate routes of one source processor
// ****************************************
`include "noc_defines.svh"

module route_lookup
    import noc_pkg::*;
#(
    parameter int unsigned src = 0
)
(
    input  proc_req_t                     req,
    input  logic [`NOC_PATHS_PER_SRC-1:0] path_free_src,
    output route_t                        primary,
    output route_t                        alternate
);

    localparam int unsigned base = src * `NOC_PATHS_PER_SRC;  // first global route index
    localparam logic [`NOC_NODE_W-1:0] src_id = `NOC_NODE_W'(src);

    mesh_ctrl_t             route_ctrl [`NOC_PATHS_PER_SRC];
    logic [`NOC_NODE_W-1:0] rel;
    logic                   is_local;
    logic [2:0]             prim_off;
    logic [2:0]             alt_off;

    // set one output of a router word
    function automatic router_ctrl_t drive_output(input router_ctrl_t rc, input port_e port,
                                                  input in_sel_e sel);
        case (port)
            NORTH:   rc.sel_north = sel;
            SOUTH:   rc.sel_south = sel;
            EAST:    rc.sel_east  = sel;
            WEST:    rc.sel_west  = sel;
            default: rc.sel_proc  = sel;
        endcase
        rc.active[`NOC_NUM_PORTS - 1 - int'(port)] = 1'b1;
        return rc;
    endfunction

    // a flow leaving on dir arrives at the opposite port
    function automatic in_sel_e entry_sel(input port_e dir);
        case (dir)
            NORTH:   return FROM_SOUTH;
            SOUTH:   return FROM_NORTH;
            EAST:    return FROM_WEST;
            WEST:    return FROM_EAST;
            default: return FROM_PROC;
        endcase
    endfunction

    function automatic int step(input int node, input port_e dir);
        case (dir)
            NORTH:   return node + 2;  // one row up
            SOUTH:   return node - 2;
            EAST:    return node + 1;
            WEST:    return node - 1;
            default: return node;
        endcase
    endfunction

    // walk the hops from the source router, then deliver to PROC
    function automatic mesh_ctrl_t build_route(input int idx, input int len,
                                               input port_e d0, input port_e d1,
                                               input port_e d2);
        mesh_ctrl_t m;
        port_e      hops [3];
        int         node;
        in_sel_e    from;
        m       = '0;
        hops[0] = d0;
        hops[1] = d1;
        hops[2] = d2;
        node    = idx / `NOC_PATHS_PER_SRC;
        from    = FROM_PROC;
        for (int h = 0; h < 3; h++)
        begin
            if (h < len)
            begin
                m[node] = drive_output(m[node], hops[h], from);
                from    = entry_sel(hops[h]);
                node    = step(node, hops[h]);
            end
        end
        m[node] = drive_output(m[node], PROC, from);
        return m;
    endfunction

    // idx is the global route index, same as its path_free bit
    function automatic mesh_ctrl_t table_ctrl(input int idx);
        case (idx)
            0:       return build_route(idx, 0, PROC, PROC, PROC);
            1:       return build_route(idx, 1, EAST, PROC, PROC);
            2:       return build_route(idx, 3, NORTH, EAST, SOUTH);
            3:       return build_route(idx, 1, NORTH, PROC, PROC);
            4:       return build_route(idx, 3, EAST, NORTH, WEST);
            5:       return build_route(idx, 2, NORTH, EAST, PROC);
            6:       return build_route(idx, 2, EAST, NORTH, PROC);
            7:       return build_route(idx, 0, PROC, PROC, PROC);
            8:       return build_route(idx, 1, WEST, PROC, PROC);
            9:       return build_route(idx, 3, NORTH, WEST, SOUTH);
            10:      return build_route(idx, 1, NORTH, PROC, PROC);
            11:      return build_route(idx, 3, WEST, NORTH, EAST);
            12:      return build_route(idx, 2, NORTH, WEST, PROC);
            13:      return build_route(idx, 2, WEST, NORTH, PROC);
            14:      return build_route(idx, 0, PROC, PROC, PROC);
            15:      return build_route(idx, 1, EAST, PROC, PROC);
            16:      return build_route(idx, 3, SOUTH, EAST, NORTH);
            17:      return build_route(idx, 1, SOUTH, PROC, PROC);
            18:      return build_route(idx, 3, EAST, SOUTH, WEST);
            19:      return build_route(idx, 2, EAST, SOUTH, PROC);
            20:      return build_route(idx, 2, SOUTH, EAST, PROC);
            21:      return build_route(idx, 0, PROC, PROC, PROC);
            22:      return build_route(idx, 1, WEST, PROC, PROC);
            23:      return build_route(idx, 3, SOUTH, WEST, NORTH);
            24:      return build_route(idx, 1, SOUTH, PROC, PROC);
            25:      return build_route(idx, 3, WEST, SOUTH, EAST);
            26:      return build_route(idx, 2, SOUTH, WEST, PROC);
            27:      return build_route(idx, 2, WEST, SOUTH, PROC);
            default: return '0;
        endcase
    endfunction

    always_comb
    begin
        for (int k = 0; k < `NOC_PATHS_PER_SRC; k++)
        begin
            route_ctrl[k] = table_ctrl(base + k);
        end
    end

    // dest ^ src picks the pair: 1 horizontal, 2 vertical, 3 diagonal
    assign rel      = req.dest ^ src_id;
    assign is_local = (rel == '0);
    assign prim_off = is_local ? 3'd0 : {rel, 1'b0} - 3'd1;
    assign alt_off  = {rel, 1'b0};

    assign primary.valid   = req.req && path_free_src[prim_off];
    assign primary.ctrl    = route_ctrl[prim_off];
    assign alternate.valid = req.req && !is_local && path_free_src[alt_off];  // local has none
    assign alternate.ctrl  = route_ctrl[alt_off];

endmodule

/* design/route_arbiter.sv */
// ****************************************
// route arbiter: fixed priority P0 first,
// output port conflict check, merge, regs
// ****************************************
`include "noc_defines.svh"

module route_arbiter
    import noc_pkg::*;
(
    input  logic                              R0_control_signals1,
    input  logic                              reset,
    input  route_t [`NOC_NUM_NODES-1:0]       primary,
    input  route_t [`NOC_NUM_NODES-1:0]       alternate,
    output mesh_ctrl_t                        router_ctrl,
    output logic [`NOC_NUM_NODES-1:0]         response
);

    mesh_ctrl_t                merged_ctrl;  // next router words
    logic [`NOC_NUM_NODES-1:0] grant;

    // active outputs of every router in a route
    function automatic logic [`NOC_NUM_NODES-1:0][`NOC_NUM_PORTS-1:0] ports_of(
        input mesh_ctrl_t m);
        logic [`NOC_NUM_NODES-1:0][`NOC_NUM_PORTS-1:0] p;
        for (int n = 0; n < `NOC_NUM_NODES; n++)
        begin
            p[n] = m[n].active;
        end
        return p;
    endfunction

    function automatic logic fits(input route_t r,
        input logic [`NOC_NUM_NODES-1:0][`NOC_NUM_PORTS-1:0] claimed);
        return r.valid && ((ports_of(r.ctrl) & claimed) == '0);
    endfunction

    always_comb
    begin : arbitrate
        logic [`NOC_NUM_NODES-1:0][`NOC_NUM_PORTS-1:0] claimed;
        route_t                                        pick;
        logic                                          hit;
        claimed     = '0;
        merged_ctrl = '0;
        grant       = '0;
        for (int p = 0; p < `NOC_NUM_NODES; p++)
        begin
            hit  = 1'b1;
            pick = '0;
            if (fits(primary[p], claimed))
            begin
                pick = primary[p];
            end
            else if (fits(alternate[p], claimed))  // fallback route
            begin
                pick = alternate[p];
            end
            else
            begin
                hit = 1'b0;
            end
            if (hit)
            begin
                grant[p]    = 1'b1;
                merged_ctrl = merged_ctrl | pick.ctrl;  // ports are disjoint here
                claimed     = claimed | ports_of(pick.ctrl);
            end
        end
    end

    always_ff @(posedge R0_control_signals1 or posedge reset)
    begin
        if (reset)
        begin
            router_ctrl <= '0;
            response    <= '0;
        end
        else
        begin
            router_ctrl <= merged_ctrl;
            response    <= grant;  // repeats while request held
        end
    end

endmodule

/* design/noc_path_master.sv */
// ****************************************
// NoC path master for the 2x2 mesh top
// ****************************************
`include "noc_defines.svh"

module noc_path_master
    import noc_pkg::*;
(
    input  logic                          R0_control_signals1,
    input  logic                          reset,
    input  logic [`NOC_NUM_PATHS-1:0]     path_free,
    input  proc_req_t [`NOC_NUM_NODES-1:0] proc_req,
    output mesh_ctrl_t                    router_ctrl,
    output logic [`NOC_NUM_NODES-1:0]     response
);

    route_t [`NOC_NUM_NODES-1:0] primary;    // candidates per source
    route_t [`NOC_NUM_NODES-1:0] alternate;

    generate
        for (genvar g = 0; g < `NOC_NUM_NODES; g++)
        begin : gen_lookup
            route_lookup #(
                .src (g)
            ) route_lookup_i (
                .req           (proc_req[g]),
                .path_free_src (path_free[g*`NOC_PATHS_PER_SRC +: `NOC_PATHS_PER_SRC]),
                .primary       (primary[g]),
                .alternate     (alternate[g])
            );
        end
    endgenerate

    route_arbiter route_arbiter_i (
        .R0_control_signals1 (R0_control_signals1),
        .reset               (reset),
        .primary             (primary),
        .alternate           (alternate),
        .router_ctrl         (router_ctrl),
        .response            (response)
    );

endmodule

/* verification/noc_path_master_props.sv */
// ****************************************
// NoC path master properties on grants
// and router control words
// ****************************************
module noc_path_master_props
    import noc_pkg::*;
(
    input logic       R0_control_signals1,
    input logic       reset,
    input mesh_ctrl_t router_ctrl,
    input logic [3:0] response
);

    logic [3:0] proc_out;  // PROC output active per router

    assign proc_out = {router_ctrl[3].active[0], router_ctrl[2].active[0],
                       router_ctrl[1].active[0], router_ctrl[0].active[0]};

    // no grant, no active output anywhere
    no_stray_output: assert property (@(posedge R0_control_signals1) disable iff (reset)
        response == '0 |-> router_ctrl == '0)
        else $error("router output active with no grant");

    // each grant ends at exactly one PROC output
    one_delivery: assert property (@(posedge R0_control_signals1) disable iff (reset)
        $countones(proc_out) == $countones(response))
        else $error("PROC outputs do not match the grants");

    quiet_after_reset: assert property (@(posedge R0_control_signals1)
        $past(reset) |-> router_ctrl == '0 && response == '0)
        else $error("outputs not zero right after reset");

endmodule

/* verification/noc_path_master_tb.sv */
// ****************************************
// NoC path master testbench, reference
// model and per-cycle compare of outputs
// ****************************************
`include "noc_defines.svh"

module noc_path_master_tb
    import noc_pkg::*;
();

    logic                           R0_control_signals1;
    logic                           reset;
    logic [`NOC_NUM_PATHS-1:0]      path_free;
    proc_req_t [`NOC_NUM_NODES-1:0] proc_req;
    mesh_ctrl_t                     router_ctrl;
    logic [`NOC_NUM_NODES-1:0]      response;
    logic [31:0]                    lfsr;
    int                             errors;
    int                             checks;
    int                             tests;
    int                             mark;  // error count when the current test began

    // hops after the source router, delivery to PROC is implied
    string route_hops [`NOC_NUM_PATHS] = '{
        "", "E", "NES", "N", "ENW", "NE", "EN",
        "", "W", "NWS", "N", "WNE", "NW", "WN",
        "", "E", "SEN", "S", "ESW", "ES", "SE",
        "", "W", "SWN", "S", "WSE", "SW", "WS"};
    // primary index by source * 4 + dest, alternate follows it
    int prim_index [16] = '{0, 1, 3, 5, 8, 7, 12, 10, 17, 19, 14, 15, 26, 24, 22, 21};

    noc_path_master noc_path_master_i (
        .R0_control_signals1 (R0_control_signals1),
        .reset               (reset),
        .path_free           (path_free),
        .proc_req            (proc_req),
        .router_ctrl         (router_ctrl),
        .response            (response)
    );

    bind noc_path_master noc_path_master_props props_i (
        .R0_control_signals1 (R0_control_signals1),
        .reset               (reset),
        .router_ctrl         (router_ctrl),
        .response            (response)
    );

    function automatic int port_index(input byte c);
        case (c)
            "N":     return 0;
            "S":     return 1;
            "E":     return 2;
            "W":     return 3;
            default: return 4;  // processor
        endcase
    endfunction

    function automatic mesh_ctrl_t expand_route(input int idx);
        logic [3:0][19:0] w;
        string            hops;
        int               node;
        int               pi;
        logic [2:0]       from;
        w    = '0;
        hops = {route_hops[idx], "P"};
        node = idx / `NOC_PATHS_PER_SRC;
        from = FROM_PROC;
        for (int i = 0; i < hops.len(); i++)
        begin
            pi = port_index(hops[i]);
            w[node][19 - 3 * pi -: 3] = from;
            w[node][4 - pi]           = 1'b1;
            from = 3'(pi ^ 1);  // arrival side is the opposite port
            node = node + ((pi == 0) ? 2 : (pi == 1) ? -2 : (pi == 2) ? 1 : (pi == 3) ? -1 : 0);
        end
        return mesh_ctrl_t'(w);
    endfunction

    function automatic void ref_model(input logic [27:0] pf, input proc_req_t [3:0] rq,
                                      output mesh_ctrl_t m, output logic [3:0] g);
        mesh_ctrl_t  cand;
        logic [19:0] used;
        logic [19:0] need;
        int          idx;
        m    = '0;
        g    = '0;
        used = '0;
        for (int p = 0; p < 4; p++)
        begin
            for (int a = 0; a < 2; a++)
            begin
                idx  = prim_index[p * 4 + int'(rq[p].dest)] + a;
                cand = expand_route(idx);
                need = {cand[3].active, cand[2].active, cand[1].active, cand[0].active};
                if (rq[p].req && !g[p] && !(a == 1 && int'(rq[p].dest) == p) && pf[idx]
                    && (need & used) == '0)
                begin
                    g[p] = 1'b1;
                    m    = m | cand;
                    used = used | need;
                end
            end
        end
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic check_ctrl(input int n, input router_ctrl_t got, input router_ctrl_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAILED at %0t: router %0d control %h, expected %h", $time, n, got, exp);
        end
    endtask

    task automatic check_response(input logic [3:0] got, input logic [3:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAILED at %0t: response %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic next_cycle();
        @(posedge R0_control_signals1);
        #1;
    endtask

    task automatic wait_grant(input logic [3:0] want);
        int n;
        n = 0;
        next_cycle();
        while (response !== want && n < 8)
        begin
            next_cycle();
            n++;
        end
        if (response !== want)
        begin
            errors++;
            $display("timeout: response never became %b within 8 cycles", want);
        end
    endtask

    task automatic run_case(input proc_req_t [3:0] rq, input logic [27:0] pf,
                            input logic [3:0] want);
        next_cycle();
        proc_req  = rq;
        path_free = pf;
        wait_grant(want);
        proc_req = '0;
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %-12s done, %0d mismatches", name, errors - mark);
        mark = errors;
    endtask

    initial
    begin
        R0_control_signals1 = 1'b0;
        forever #2 R0_control_signals1 = ~R0_control_signals1;
    end

    initial
    begin : compare
        mesh_ctrl_t exp_ctrl;
        logic [3:0] exp_resp;
        forever
        begin
            @(posedge R0_control_signals1);
            exp_ctrl = '0;
            exp_resp = '0;
            if (!reset)
            begin
                ref_model(path_free, proc_req, exp_ctrl, exp_resp);
            end
            #2;  // registers settled, next drive not yet sampled
            for (int n = 0; n < 4; n++)
            begin
                check_ctrl(n, router_ctrl[n], exp_ctrl[n]);
            end
            check_response(response, exp_resp);
        end
    end

    initial
    begin : stimulus
        proc_req_t [3:0] rq;
        logic [27:0]     pf;
        logic [31:0]     bits;
        int              pidx;
        reset     = 1'b1;
        path_free = '0;
        proc_req  = '0;
        lfsr      = 32'h4a4f;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        mark      = 0;
        repeat (3) @(posedge R0_control_signals1);
        #1 reset = 1'b0;
        repeat (4) next_cycle();
        finish_test("reset_idle");
        for (int s = 0; s < 4; s++)
        begin
            rq    = '0;
            rq[s] = '{dest: 2'(s), req: 1'b1};
            run_case(rq, '1, 4'(1 << s));
        end
        finish_test("local");
        for (int s = 0; s < 4; s++)
        begin
            for (int d = 0; d < 4; d++)
            begin
                if (d != s)
                begin
                    rq    = '0;
                    rq[s] = '{dest: 2'(d), req: 1'b1};
                    pidx  = prim_index[s * 4 + d];
                    run_case(rq, '1, 4'(1 << s));
                    pf = '1;
                    pf[pidx] = 1'b0;  // alternate takes over
                    run_case(rq, pf, 4'(1 << s));
                    pf[pidx + 1] = 1'b0;
                    run_case(rq, pf, 4'b0000);
                end
            end
        end
        finish_test("prim_alt");
        rq = '0;
        rq[0] = '{dest: 2'd3, req: 1'b1};
        rq[2] = '{dest: 2'd3, req: 1'b1};
        run_case(rq, '1, 4'b0001);  // R2 east and R3 proc both taken by P0
        rq[2] = '{dest: 2'd1, req: 1'b1};
        run_case(rq, '1, 4'b0101);  // P2 falls back to route 20
        for (int s = 0; s < 4; s++)
        begin
            rq[s] = '{dest: 2'(s), req: 1'b1};
        end
        run_case(rq, '1, 4'b1111);
        for (int s = 0; s < 4; s++)
        begin
            rq[s] = '{dest: 2'(3 - s), req: 1'b1};  // every pair diagonal
        end
        run_case(rq, '1, 4'b1111);
        finish_test("priority");
        repeat (300)
        begin
            next_cycle();
            take_bits(28, bits);
            path_free = bits[27:0];
            for (int p = 0; p < 4; p++)
            begin
                take_bits(3, bits);
                proc_req[p] = proc_req_t'(bits[2:0]);
            end
        end
        next_cycle();
        proc_req = '0;
        repeat (2) next_cycle();
        finish_test("random");
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
        begin
            $display("** PASS **");
        end
        else
        begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+design
design/noc_pkg.sv
design/route_lookup.sv
design/route_arbiter.sv
design/noc_path_master.sv
verification/noc_path_master_props.sv
verification/noc_path_master_tb.sv

/* run.sh */
#!/usr/bin/env bash
# compile and run the NoC path master testbench with Verilator
set -e
set -o pipefail

verilator --binary --timing --assert -Wno-fatal \
    -f files.f \
    --top-module noc_path_master_tb \
    -o noc_path_master_sim

./obj_dir/noc_path_master_sim | tee sim.log

if grep -qF "** FAIL **" sim.log; then
    echo "simulation reported errors, see sim.log"
    exit 1
fi
echo "simulation finished without errors"
